/* lc3b_pkg.sv */
package lc3b_pkg;

typedef logic [15:0] lc3b_word;    // data word or byte address
typedef logic [2:0]  lc3b_reg;     // register index
typedef logic [2:0]  lc3b_nzp;     // n in bit 2

typedef enum logic [3:0]
{
    op_br  = 4'd0,
    op_add = 4'd1,
    op_and = 4'd5,
    op_ldr = 4'd6,
    op_str = 4'd7,
    op_not = 4'd9
} lc3b_opcode;

typedef enum logic [1:0]
{
    alu_add,
    alu_and,
    alu_not,
    alu_pass
} lc3b_aluop;

typedef enum logic [1:0]
{
    fwd_none,
    fwd_mem,
    fwd_wb
} lc3b_fwd_sel;

// br with an empty nzp mask
localparam lc3b_word NOP_WORD = 16'h0000;

localparam lc3b_word PC_STEP = 16'd2;    // one instruction

localparam int OPCODE_LSB   = 12;
localparam int DEST_LSB     = 9;         // dest, store source or nzp
localparam int SRC_A_LSB    = 6;
localparam int IMM_FLAG_BIT = 5;

endpackage : lc3b_pkg

/* lc3b_regfile.sv */
module lc3b_regfile
(
    input  logic               clk,
    input  logic               rst_n,
    input  lc3b_pkg::lc3b_reg  src_a,
    input  lc3b_pkg::lc3b_reg  src_b,
    output lc3b_pkg::lc3b_word reg_a,
    output lc3b_pkg::lc3b_word reg_b,
    input  logic               we,
    input  lc3b_pkg::lc3b_reg  dest,
    input  lc3b_pkg::lc3b_word wdata
);

lc3b_pkg::lc3b_word regs [8];

always_ff @(posedge clk)
begin
    if (!rst_n)
    begin
        for (int i = 0; i < 8; i++)
            regs[i] <= '0;
    end
    else if (we)
    begin
        regs[dest] <= wdata;
    end
end

// writeback result visible in the same cycle
assign reg_a = (we && dest == src_a) ? wdata : regs[src_a];
assign reg_b = (we && dest == src_b) ? wdata : regs[src_b];

endmodule : lc3b_regfile

/* lc3b_fetch.sv */
module lc3b_fetch
#(
    parameter lc3b_pkg::lc3b_word RESET_PC = 16'h0000
)
(
    input  logic               clk,
    input  logic               rst_n,
    output logic               i_cyc,
    output logic               i_stb,
    output lc3b_pkg::lc3b_word i_adr,
    input  lc3b_pkg::lc3b_word i_dat,
    input  logic               i_ack,
    input  logic               advance,
    input  logic               hold,
    input  logic               flush,
    input  logic               br_taken,
    input  lc3b_pkg::lc3b_word br_target,
    output lc3b_pkg::lc3b_word instr,
    output lc3b_pkg::lc3b_word instr_pc
);

lc3b_pkg::lc3b_word pc;
lc3b_pkg::lc3b_word pc_plus2;

assign pc_plus2 = pc + lc3b_pkg::PC_STEP;

assign i_cyc = 1'b1;            // always fetching
assign i_stb = i_cyc;
assign i_adr = pc;              // held until the pipeline advances

always_ff @(posedge clk)
begin
    if (!rst_n)
    begin
        pc       <= RESET_PC;
        instr    <= lc3b_pkg::NOP_WORD;
        instr_pc <= RESET_PC;
    end
    else if (advance && i_ack)
    begin
        if (flush)
            instr <= lc3b_pkg::NOP_WORD;     // word behind a taken branch
        else if (!hold)
        begin
            instr    <= i_dat;
            instr_pc <= pc_plus2;           // base for br targets
        end

        if (br_taken)
            pc <= br_target;
        else if (!hold)
            pc <= pc_plus2;
    end
end

endmodule : lc3b_fetch

/* lc3b_decode.sv */
module lc3b_decode
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  lc3b_pkg::lc3b_word   instr,
    input  lc3b_pkg::lc3b_word   instr_pc,
    input  logic                 advance,
    input  logic                 bubble,
    input  logic                 flush,
    input  logic                 wb_wr_reg,
    input  lc3b_pkg::lc3b_reg    wb_dest,
    input  lc3b_pkg::lc3b_word   wb_result,
    output lc3b_pkg::lc3b_reg    src_a,
    output lc3b_pkg::lc3b_reg    src_b,
    output lc3b_pkg::lc3b_opcode ex_opcode,
    output lc3b_pkg::lc3b_aluop  ex_aluop,
    output lc3b_pkg::lc3b_reg    ex_dest,
    output lc3b_pkg::lc3b_reg    ex_src_a,
    output lc3b_pkg::lc3b_reg    ex_src_b,
    output logic                 ex_use_imm,
    output lc3b_pkg::lc3b_word   ex_imm,
    output lc3b_pkg::lc3b_word   ex_a,
    output lc3b_pkg::lc3b_word   ex_b,
    output lc3b_pkg::lc3b_word   ex_pc
);

lc3b_pkg::lc3b_word   reg_a;
lc3b_pkg::lc3b_word   reg_b;
logic [3:0]           op_field;
lc3b_pkg::lc3b_opcode opcode;
lc3b_pkg::lc3b_aluop  aluop;
lc3b_pkg::lc3b_reg    dest;
lc3b_pkg::lc3b_word   imm;
logic                 use_imm;

assign op_field = instr[lc3b_pkg::OPCODE_LSB +: 4];
assign src_a    = instr[lc3b_pkg::SRC_A_LSB +: 3];

// str sends its data register through the second read port
assign src_b = (op_field == lc3b_pkg::op_str) ? instr[lc3b_pkg::DEST_LSB +: 3] : instr[2:0];

lc3b_regfile regfile
(
    .clk   (clk),
    .rst_n (rst_n),
    .src_a (src_a),
    .src_b (src_b),
    .reg_a (reg_a),
    .reg_b (reg_b),
    .we    (wb_wr_reg),
    .dest  (wb_dest),
    .wdata (wb_result)
);

always_comb
begin
    opcode  = lc3b_pkg::op_br;
    aluop   = lc3b_pkg::alu_pass;
    dest    = instr[lc3b_pkg::DEST_LSB +: 3];
    use_imm = 1'b0;
    imm     = {{6{instr[8]}}, instr[8:0], 1'b0};     // offset9 for br
    case (op_field)
        lc3b_pkg::op_br:
            opcode = lc3b_pkg::op_br;
        lc3b_pkg::op_add:
        begin
            opcode  = lc3b_pkg::op_add;
            aluop   = lc3b_pkg::alu_add;
            use_imm = instr[lc3b_pkg::IMM_FLAG_BIT];
            imm     = {{11{instr[4]}}, instr[4:0]};
        end
        lc3b_pkg::op_and:
        begin
            opcode  = lc3b_pkg::op_and;
            aluop   = lc3b_pkg::alu_and;
            use_imm = instr[lc3b_pkg::IMM_FLAG_BIT];
            imm     = {{11{instr[4]}}, instr[4:0]};
        end
        lc3b_pkg::op_not:
        begin
            opcode = lc3b_pkg::op_not;
            aluop  = lc3b_pkg::alu_not;
        end
        lc3b_pkg::op_ldr, lc3b_pkg::op_str:
        begin
            opcode  = (op_field == lc3b_pkg::op_ldr) ? lc3b_pkg::op_ldr : lc3b_pkg::op_str;
            aluop   = lc3b_pkg::alu_add;          // base plus offset
            use_imm = 1'b1;
            imm     = {{9{instr[5]}}, instr[5:0], 1'b0};
        end
        default:
            dest = '0;                            // unsupported, br never
    endcase
end

always_ff @(posedge clk)
begin
    if (!rst_n || (advance && (bubble || flush)))
    begin
        ex_opcode  <= lc3b_pkg::op_br;            // no-op into execute
        ex_aluop   <= lc3b_pkg::alu_pass;
        ex_dest    <= '0;
        ex_src_a   <= '0;
        ex_src_b   <= '0;
        ex_use_imm <= 1'b0;
    end
    else if (advance)
    begin
        ex_opcode  <= opcode;
        ex_aluop   <= aluop;
        ex_dest    <= dest;
        ex_src_a   <= src_a;
        ex_src_b   <= src_b;
        ex_use_imm <= use_imm;
    end
end

always_ff @(posedge clk)
begin
    if (advance)
    begin
        ex_imm <= imm;
        ex_a   <= reg_a;
        ex_b   <= reg_b;
        ex_pc  <= instr_pc;
    end
end

endmodule : lc3b_decode

/* lc3b_hazard.sv */
module lc3b_hazard
(
    input  lc3b_pkg::lc3b_reg     src_a,
    input  lc3b_pkg::lc3b_reg     src_b,
    input  lc3b_pkg::lc3b_reg     ex_src_a,
    input  lc3b_pkg::lc3b_reg     ex_src_b,
    input  lc3b_pkg::lc3b_opcode  ex_opcode,
    input  lc3b_pkg::lc3b_reg     ex_dest,
    input  lc3b_pkg::lc3b_reg     mem_dest,
    input  logic                  mem_wr_reg,
    input  lc3b_pkg::lc3b_reg     wb_dest,
    input  logic                  wb_wr_reg,
    output lc3b_pkg::lc3b_fwd_sel fwd_a,
    output lc3b_pkg::lc3b_fwd_sel fwd_b,
    output logic                  bubble
);

function automatic lc3b_pkg::lc3b_fwd_sel pick_fwd(input lc3b_pkg::lc3b_reg src);
    if (mem_wr_reg && mem_dest == src)
        return lc3b_pkg::fwd_mem;           // younger result wins
    if (wb_wr_reg && wb_dest == src)
        return lc3b_pkg::fwd_wb;
    return lc3b_pkg::fwd_none;
endfunction

always_comb
begin
    fwd_a = pick_fwd(ex_src_a);
    fwd_b = pick_fwd(ex_src_b);
end

// load data only exists after the memory stage
assign bubble = (ex_opcode == lc3b_pkg::op_ldr) && (src_a == ex_dest || src_b == ex_dest);

endmodule : lc3b_hazard

/* lc3b_execute.sv */
module lc3b_execute
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  lc3b_pkg::lc3b_opcode  ex_opcode,
    input  lc3b_pkg::lc3b_aluop   ex_aluop,
    input  lc3b_pkg::lc3b_reg     ex_dest,
    input  logic                  ex_use_imm,
    input  lc3b_pkg::lc3b_word    ex_imm,
    input  lc3b_pkg::lc3b_word    ex_a,
    input  lc3b_pkg::lc3b_word    ex_b,
    input  lc3b_pkg::lc3b_word    ex_pc,
    input  lc3b_pkg::lc3b_fwd_sel fwd_a,
    input  lc3b_pkg::lc3b_fwd_sel fwd_b,
    input  lc3b_pkg::lc3b_word    wb_result,
    input  logic                  advance,
    input  logic                  flush,
    output lc3b_pkg::lc3b_opcode  mem_opcode,
    output lc3b_pkg::lc3b_reg     mem_dest,
    output logic                  mem_wr_reg,
    output lc3b_pkg::lc3b_word    mem_result,
    output lc3b_pkg::lc3b_word    mem_store_data,
    output lc3b_pkg::lc3b_nzp     mem_nzp_mask
);

lc3b_pkg::lc3b_word opa;
lc3b_pkg::lc3b_word opb;
lc3b_pkg::lc3b_word alu_b;
lc3b_pkg::lc3b_word alu_out;
lc3b_pkg::lc3b_word br_target;
lc3b_pkg::lc3b_word result;
logic               wr_reg;

always_comb
begin
    case (fwd_a)
        lc3b_pkg::fwd_mem: opa = mem_result;
        lc3b_pkg::fwd_wb:  opa = wb_result;
        default:           opa = ex_a;
    endcase
    case (fwd_b)
        lc3b_pkg::fwd_mem: opb = mem_result;
        lc3b_pkg::fwd_wb:  opb = wb_result;
        default:           opb = ex_b;
    endcase
end

assign alu_b = ex_use_imm ? ex_imm : opb;

always_comb
begin
    case (ex_aluop)
        lc3b_pkg::alu_add: alu_out = opa + alu_b;    // also ldr/str address
        lc3b_pkg::alu_and: alu_out = opa & alu_b;
        lc3b_pkg::alu_not: alu_out = ~opa;
        default:           alu_out = alu_b;
    endcase
end

assign br_target = ex_pc + ex_imm;    // pc already incremented
assign result    = (ex_opcode == lc3b_pkg::op_br) ? br_target : alu_out;

assign wr_reg = ex_opcode inside {lc3b_pkg::op_add, lc3b_pkg::op_and,
                                  lc3b_pkg::op_not, lc3b_pkg::op_ldr};

always_ff @(posedge clk)
begin
    if (!rst_n || (advance && flush))
    begin
        mem_opcode   <= lc3b_pkg::op_br;
        mem_dest     <= '0;
        mem_wr_reg   <= 1'b0;
        mem_nzp_mask <= '0;                 // never taken
    end
    else if (advance)
    begin
        mem_opcode   <= ex_opcode;
        mem_dest     <= ex_dest;
        mem_wr_reg   <= wr_reg;
        mem_nzp_mask <= (ex_opcode == lc3b_pkg::op_br) ? ex_dest : '0;
    end
end

always_ff @(posedge clk)
begin
    if (advance)
    begin
        mem_result     <= result;
        mem_store_data <= opb;              // str source after forwarding
    end
end

endmodule : lc3b_execute

/* lc3b_memory.sv */
module lc3b_memory
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  lc3b_pkg::lc3b_opcode mem_opcode,
    input  lc3b_pkg::lc3b_reg    mem_dest,
    input  logic                 mem_wr_reg,
    input  lc3b_pkg::lc3b_word   mem_result,
    input  lc3b_pkg::lc3b_word   mem_store_data,
    input  lc3b_pkg::lc3b_nzp    mem_nzp_mask,
    input  logic                 advance,
    input  lc3b_pkg::lc3b_word   d_dat_r,
    input  logic                 d_ack,
    output logic                 d_cyc,
    output logic                 d_stb,
    output logic                 d_we,
    output lc3b_pkg::lc3b_word   d_adr,
    output lc3b_pkg::lc3b_word   d_dat_w,
    output logic                 mem_wait,
    output logic                 br_taken,
    output lc3b_pkg::lc3b_reg    wb_dest,
    output logic                 wb_wr_reg,
    output lc3b_pkg::lc3b_word   wb_result
);

logic               is_load;
logic               is_store;
logic               d_done;
lc3b_pkg::lc3b_word ld_data;
lc3b_pkg::lc3b_word wb_in;
lc3b_pkg::lc3b_nzp  cc;

function automatic lc3b_pkg::lc3b_nzp gen_cc(input lc3b_pkg::lc3b_word value);
    if (value[15])
        return 3'b100;
    if (value == '0)
        return 3'b010;
    return 3'b001;
endfunction

assign is_load  = mem_opcode == lc3b_pkg::op_ldr;
assign is_store = mem_opcode == lc3b_pkg::op_str;

assign d_cyc    = (is_load || is_store) && !d_done;    // one transfer per access
assign d_stb    = d_cyc;
assign d_we     = is_store;
assign d_adr    = mem_result;
assign d_dat_w  = mem_store_data;
assign mem_wait = d_cyc && !d_ack;

always_ff @(posedge clk)
begin
    if (!rst_n || advance)
        d_done <= 1'b0;
    else if (d_cyc && d_ack)
        d_done <= 1'b1;                     // acked, waiting on fetch
end

always_ff @(posedge clk)
begin
    if (d_cyc && d_ack)
        ld_data <= d_dat_r;
end

assign wb_in = !is_load ? mem_result : (d_done ? ld_data : d_dat_r);

// nzp mask is zero for everything but br
assign br_taken = (mem_opcode == lc3b_pkg::op_br) && |(mem_nzp_mask & cc);

always_ff @(posedge clk)
begin
    if (!rst_n)
    begin
        cc        <= '0;
        wb_dest   <= '0;
        wb_wr_reg <= 1'b0;
    end
    else if (advance)
    begin
        wb_dest   <= mem_dest;
        wb_wr_reg <= mem_wr_reg;
        if (mem_wr_reg)
            cc <= gen_cc(wb_in);            // set as result enters writeback
    end
end

always_ff @(posedge clk)
begin
    if (advance)
        wb_result <= wb_in;
end

endmodule : lc3b_memory

/* lc3b_pipe.sv */
module lc3b_pipe
#(
    parameter lc3b_pkg::lc3b_word RESET_PC = 16'h0000
)
(
    input  logic               clk,
    input  logic               rst_n,
    output logic               i_cyc,
    output logic               i_stb,
    output lc3b_pkg::lc3b_word i_adr,
    input  lc3b_pkg::lc3b_word i_dat,
    input  logic               i_ack,
    output logic               d_cyc,
    output logic               d_stb,
    output logic               d_we,
    output lc3b_pkg::lc3b_word d_adr,
    output lc3b_pkg::lc3b_word d_dat_w,
    input  lc3b_pkg::lc3b_word d_dat_r,
    input  logic               d_ack
);

logic                  advance;
logic                  mem_wait;
logic                  bubble;
logic                  br_taken;
lc3b_pkg::lc3b_word    instr;
lc3b_pkg::lc3b_word    instr_pc;
lc3b_pkg::lc3b_reg     src_a;
lc3b_pkg::lc3b_reg     src_b;
lc3b_pkg::lc3b_opcode  ex_opcode;
lc3b_pkg::lc3b_aluop   ex_aluop;
lc3b_pkg::lc3b_reg     ex_dest;
lc3b_pkg::lc3b_reg     ex_src_a;
lc3b_pkg::lc3b_reg     ex_src_b;
logic                  ex_use_imm;
lc3b_pkg::lc3b_word    ex_imm;
lc3b_pkg::lc3b_word    ex_a;
lc3b_pkg::lc3b_word    ex_b;
lc3b_pkg::lc3b_word    ex_pc;
lc3b_pkg::lc3b_fwd_sel fwd_a;
lc3b_pkg::lc3b_fwd_sel fwd_b;
lc3b_pkg::lc3b_opcode  mem_opcode;
lc3b_pkg::lc3b_reg     mem_dest;
logic                  mem_wr_reg;
lc3b_pkg::lc3b_word    mem_result;
lc3b_pkg::lc3b_word    mem_store_data;
lc3b_pkg::lc3b_nzp     mem_nzp_mask;
lc3b_pkg::lc3b_reg     wb_dest;
logic                  wb_wr_reg;
lc3b_pkg::lc3b_word    wb_result;

// whole pipeline moves together once both ports are satisfied
assign advance = i_ack && !mem_wait;

lc3b_fetch #(.RESET_PC(RESET_PC)) fetch_stage
(
    .hold      (bubble),
    .flush     (br_taken),
    .br_target (mem_result),            // br target rides in the result field
    .*
);

lc3b_decode decode_stage
(
    .flush (br_taken),
    .*
);

lc3b_hazard hazard_unit
(
    .*
);

lc3b_execute execute_stage
(
    .flush (br_taken),
    .*
);

lc3b_memory memory_stage
(
    .*
);

endmodule : lc3b_pipe

/* lc3b_pipe_sva.sv */
module lc3b_pipe_sva
(
    input logic               clk,
    input logic               rst_n,
    input logic               i_cyc,
    input logic               i_stb,
    input lc3b_pkg::lc3b_word i_adr,
    input logic               i_ack,
    input logic               d_cyc,
    input logic               d_stb,
    input logic               d_we,
    input lc3b_pkg::lc3b_word d_adr,
    input lc3b_pkg::lc3b_word d_dat_w,
    input logic               d_ack
);

timeunit 1ns;
timeprecision 1ps;

d_stb_in_cycle: assert property (@(posedge clk) disable iff (!rst_n) d_stb |-> d_cyc)
    else $error("d_stb raised outside a data cycle");

// request held until the slave answers
d_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (d_stb && !d_ack) |=> d_stb && $stable(d_adr) && $stable(d_dat_w) && $stable(d_we))
    else $error("data request changed before d_ack");

i_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (i_stb && !i_ack) |=> i_stb && $stable(i_adr))
    else $error("instruction address changed before i_ack");

i_cyc_after_reset: assert property (@(posedge clk) rst_n |-> i_cyc && i_stb)
    else $error("instruction cycle not active after reset");

d_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !d_cyc)
    else $error("data cycle active on the first cycle after reset");

endmodule : lc3b_pipe_sva

bind lc3b_pipe lc3b_pipe_sva wb_checks (.*);

/* tb_lc3b_pipe.sv */
module tb_lc3b_pipe;

timeunit 1ns;
timeprecision 1ps;

localparam lc3b_pkg::lc3b_word RESET_PC = 16'h0040;
localparam int PROG_BASE = RESET_PC[8:1];            // imem word of the first instruction
localparam lc3b_pkg::lc3b_word MARK_ADR = 16'd62;    // last store of every program
localparam int MAX_CYCLES = 4000;                    // seven tests of ~40 instr, up to 4 waits each

logic               clk = 1'b0;
logic               rst_n;
logic               i_cyc;
logic               i_stb;
lc3b_pkg::lc3b_word i_adr;
lc3b_pkg::lc3b_word i_dat;
logic               i_ack;
logic               d_cyc;
logic               d_stb;
logic               d_we;
lc3b_pkg::lc3b_word d_adr;
lc3b_pkg::lc3b_word d_dat_w;
lc3b_pkg::lc3b_word d_dat_r;
logic               d_ack;

lc3b_pkg::lc3b_word imem [256];
lc3b_pkg::lc3b_word dmem [256];
lc3b_pkg::lc3b_word prog [$];
lc3b_pkg::lc3b_word exp_adr [$];
lc3b_pkg::lc3b_word exp_val [$];
lc3b_pkg::lc3b_word got_adr [$];
lc3b_pkg::lc3b_word got_val [$];
lc3b_pkg::lc3b_word first_fetch;

bit     random_waits = 1'b0;
integer seed = 20;
int     i_wait = 0;
int     d_wait = 0;
bit     marker_seen;
int     reads_seen;
int     cycles = 0;
int     checks = 0;
int     errors = 0;

lc3b_pipe #(.RESET_PC(RESET_PC)) DUT (.*);

always #10 clk = ~clk;

function automatic int draw_wait();
    return random_waits ? int'($unsigned($random(seed)) % 4) : 0;
endfunction

// instruction and data slaves answer on the falling edge
always @(negedge clk)
begin
    if (i_cyc !== 1'b1 || i_stb !== 1'b1)
        i_ack = 1'b0;
    else if (i_wait > 0)
    begin
        i_ack = 1'b0;
        i_wait--;
    end
    else
    begin
        i_ack  = 1'b1;
        i_dat  = imem[i_adr[8:1]];
        i_wait = draw_wait();
    end
    if (d_cyc !== 1'b1 || d_stb !== 1'b1)
        d_ack = 1'b0;
    else if (d_wait > 0)
    begin
        d_ack = 1'b0;
        d_wait--;
    end
    else
    begin
        d_ack  = 1'b1;
        d_wait = draw_wait();
        if (d_we)
        begin
            dmem[d_adr[8:1]] = d_dat_w;    // transfer completes on the next rising edge
            got_adr.push_back(d_adr);
            got_val.push_back(d_dat_w);
            if (d_adr == MARK_ADR)
                marker_seen = 1'b1;
        end
        else
        begin
            d_dat_r = dmem[d_adr[8:1]];
            reads_seen++;
        end
    end
end

always @(posedge clk)
begin
    cycles++;
    if (cycles == MAX_CYCLES)
    begin
        $display("run stopped after %0d cycles, a program never reached its last store", cycles);
        $display("errors: %0d in %0d checks", errors + 1, checks);
        $display("SIMULATION FAILED");
        $finish;
    end
end

function automatic lc3b_pkg::lc3b_word alu_reg(lc3b_pkg::lc3b_opcode op, int dr, int sr1, int sr2);
    return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
endfunction

function automatic lc3b_pkg::lc3b_word alu_imm(lc3b_pkg::lc3b_opcode op, int dr, int sr1, int imm);
    return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
endfunction

function automatic lc3b_pkg::lc3b_word not_of(int dr, int sr);
    return {lc3b_pkg::op_not, 3'(dr), 3'(sr), 6'b111111};
endfunction

function automatic lc3b_pkg::lc3b_word ldst(lc3b_pkg::lc3b_opcode op, int r, int base, int off);
    return {op, 3'(r), 3'(base), 6'(off)};    // byte address = base + off * 2
endfunction

function automatic lc3b_pkg::lc3b_word branch(int nzp, int off);
    return {lc3b_pkg::op_br, 3'(nzp), 9'(off)};    // target = pc + 2 + off * 2
endfunction

task automatic put(input lc3b_pkg::lc3b_word word);
    prog.push_back(word);
endtask

task automatic expect_write(input lc3b_pkg::lc3b_word adr, input lc3b_pkg::lc3b_word val);
    exp_adr.push_back(adr);
    exp_val.push_back(val);
endtask

task automatic fill_data();
    for (int i = 0; i < 256; i++)
        dmem[i] = {8'(i) ^ 8'hA5, 8'(i)};
endtask

task automatic new_program();
    prog.delete();
    exp_adr.delete();
    exp_val.delete();
    fill_data();
endtask

// marker store then branch-to-self
task automatic end_program(input int r, input lc3b_pkg::lc3b_word val);
    put(ldst(lc3b_pkg::op_str, r, 0, 31));
    put(branch(7, -1));
    expect_write(MARK_ADR, val);
endtask

task automatic check_word(input string name, input lc3b_pkg::lc3b_word exp,
                          input lc3b_pkg::lc3b_word act);
    checks++;
    if (exp !== act)
    begin
        errors++;
        $display("FAILED %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (exp != act)
    begin
        errors++;
        $display("FAILED %s expected %0d actual %0d", name, exp, act);
    end
endtask

task automatic compare_writes(input string name);
    int n;
    check_count({name, " write count"}, exp_adr.size(), got_adr.size());
    n = (exp_adr.size() < got_adr.size()) ? exp_adr.size() : got_adr.size();
    for (int i = 0; i < n; i++)
    begin
        check_word($sformatf("%s write %0d address", name, i), exp_adr[i], got_adr[i]);
        check_word($sformatf("%s write %0d data", name, i), exp_val[i], got_val[i]);
    end
endtask

task automatic run_program(input string name);
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < 256; i++)
        imem[i] = (i >= PROG_BASE && i - PROG_BASE < prog.size()) ? prog[i - PROG_BASE]
                                                                 : lc3b_pkg::NOP_WORD;
    repeat (5) @(negedge clk);
    got_adr.delete();
    got_val.delete();
    marker_seen = 1'b0;
    reads_seen  = 0;
    rst_n       = 1'b1;
    first_fetch = i_adr;
    while (!marker_seen)
        @(negedge clk);
    compare_writes(name);
endtask

task automatic reset_behavior(input string name);
    new_program();
    put(alu_imm(lc3b_pkg::op_add, 1, 0, 3));
    put(alu_reg(lc3b_pkg::op_add, 2, 1, 1));    // r2 = 6
    end_program(2, 16'h0006);
    run_program(name);
    check_word({name, " first fetch"}, RESET_PC, first_fetch);
    check_count({name, " data reads"}, 0, reads_seen);
endtask

task automatic alu_forwarding(input string name);
    new_program();
    put(alu_imm(lc3b_pkg::op_add, 1, 0, 5));     // r1 = 5
    put(alu_imm(lc3b_pkg::op_add, 2, 1, -3));    // r2 = 2
    put(alu_reg(lc3b_pkg::op_add, 3, 1, 2));     // r3 = 7
    put(alu_imm(lc3b_pkg::op_and, 4, 3, 6));     // r4 = 6
    put(not_of(5, 4));                           // r5 = fff9
    put(alu_reg(lc3b_pkg::op_and, 6, 5, 3));     // r6 = 1
    put(alu_reg(lc3b_pkg::op_add, 7, 5, 6));     // r7 = fffa
    put(ldst(lc3b_pkg::op_str, 3, 0, 1));
    put(ldst(lc3b_pkg::op_str, 4, 0, 2));
    put(ldst(lc3b_pkg::op_str, 5, 0, 3));
    put(ldst(lc3b_pkg::op_str, 6, 0, 4));
    put(ldst(lc3b_pkg::op_str, 7, 0, 5));
    put(alu_imm(lc3b_pkg::op_and, 1, 7, -16));   // r1 = fff0
    put(ldst(lc3b_pkg::op_str, 1, 0, 6));        // store data from memory stage
    put(alu_imm(lc3b_pkg::op_add, 2, 0, 14));    // r2 = 14
    put(ldst(lc3b_pkg::op_str, 3, 2, 1));        // forwarded base
    end_program(2, 16'd14);
    expect_write(16'd2, 16'h0007);
    expect_write(16'd4, 16'h0006);
    expect_write(16'd6, 16'hFFF9);
    expect_write(16'd8, 16'h0001);
    expect_write(16'd10, 16'hFFFA);
    expect_write(16'd12, 16'hFFF0);
    expect_write(16'd16, 16'h0007);
    exp_adr.push_back(exp_adr.pop_front());     // marker goes last
    exp_val.push_back(exp_val.pop_front());
    run_program(name);
endtask

task automatic load_use_stall(input string name);
    new_program();
    dmem[10] = 16'h1234;
    dmem[11] = 16'h0042;
    put(alu_imm(lc3b_pkg::op_add, 1, 0, 10));   // r1 = 10
    put(ldst(lc3b_pkg::op_ldr, 2, 1, 5));        // r2 = mem[20]
    put(alu_imm(lc3b_pkg::op_add, 3, 2, 1));     // first source waits on load
    put(ldst(lc3b_pkg::op_str, 3, 0, 12));
    put(ldst(lc3b_pkg::op_ldr, 4, 1, 6));        // r4 = mem[22]
    put(alu_reg(lc3b_pkg::op_add, 5, 2, 4));     // second source waits on load
    put(ldst(lc3b_pkg::op_str, 5, 0, 13));
    put(ldst(lc3b_pkg::op_ldr, 6, 1, 5));
    put(ldst(lc3b_pkg::op_str, 6, 0, 14));       // store data waits on load
    expect_write(16'd24, 16'h1235);
    expect_write(16'd26, 16'h1276);
    expect_write(16'd28, 16'h1234);
    end_program(1, 16'd10);
    run_program(name);
endtask

task automatic branch_flush(input string name);
    new_program();
    put(alu_imm(lc3b_pkg::op_add, 1, 0, -2));   // n
    put(branch(3'b100, 4));                      // taken so four words are skipped
    for (int k = 8; k < 12; k++)
        put(ldst(lc3b_pkg::op_str, 1, 0, k));
    put(ldst(lc3b_pkg::op_str, 1, 0, 1));
    put(alu_imm(lc3b_pkg::op_add, 2, 0, 0));    // z
    put(branch(3'b010, 3));
    for (int k = 8; k < 11; k++)
        put(ldst(lc3b_pkg::op_str, 2, 0, k));
    put(alu_imm(lc3b_pkg::op_add, 3, 0, 7));    // p
    put(branch(3'b110, 2));                      // not taken
    put(ldst(lc3b_pkg::op_str, 3, 0, 2));
    put(branch(3'b001, 3));
    for (int k = 8; k < 11; k++)
        put(ldst(lc3b_pkg::op_str, 3, 0, k));
    put(ldst(lc3b_pkg::op_str, 2, 0, 3));
    expect_write(16'd2, 16'hFFFE);
    expect_write(16'd4, 16'h0007);
    expect_write(16'd6, 16'h0000);
    end_program(3, 16'h0007);
    run_program(name);
endtask

initial
begin
    rst_n   = 1'b0;
    i_ack   = 1'b0;
    i_dat   = '0;
    d_ack   = 1'b0;
    d_dat_r = '0;
    reset_behavior("reset");
    alu_forwarding("alu");
    load_use_stall("load_use");
    branch_flush("branch");
    random_waits = 1'b1;    // back-pressure on both ports from here
    alu_forwarding("alu_waits");
    load_use_stall("load_use_waits");
    branch_flush("branch_waits");
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0)
        $display("SIMULATION PASSED");
    else
        $display("SIMULATION FAILED");
    $finish;
end

endmodule : tb_lc3b_pipe

/* lc3b_pipe.f */
lc3b_pkg.sv
lc3b_regfile.sv
lc3b_fetch.sv
lc3b_decode.sv
lc3b_hazard.sv
lc3b_execute.sv
lc3b_memory.sv
lc3b_pipe.sv
lc3b_pipe_sva.sv
tb_lc3b_pipe.sv

/* run.sh */
#!/bin/sh
# build the core and testbench with Verilator, run, and look for the pass line
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_lc3b_pipe -f lc3b_pipe.f \
    && ./obj_dir/Vtb_lc3b_pipe | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
    && echo "lc3b_pipe run passed" \
    || { echo "lc3b_pipe run failed"; exit 1; }
